/* verilog/wb_pkg.sv */
package wb_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Integer register and data path width
  localparam int XLEN = 32;

  // Register file address width, giving x0 to x31
  localparam int RF_ADDR_W = 5;

  // Number of architectural registers, x0 included
  localparam int NUM_REGS = 2 ** RF_ADDR_W;

  ////////////////////
  // Types
  ////////////////////

  // Register file address
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // Instruction opcodes seen by EX
  // ALU operations first, word load last
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_LOAD = 3'd5
  } op_e;

  // Outcome of the load address check against the MPU region
  // Non-load instructions always carry MPU_OK
  typedef enum logic [0:0] {
    MPU_OK    = 1'b0,
    MPU_FAULT = 1'b1
  } mpu_status_e;

  // Notes on the encodings
  //
  // Opcode values 6 and 7 are unused
  // EX treats them as a zero result with no write side effect
  // beyond the normal destination write
  //
  // The MPU status travels with the instruction from EX into WB
  // WB turns a faulted load into an exception without a write
  //
  // Register address zero is hardwired
  // Writes to it are dropped both in EX and in the register file

endpackage

/* verilog/ex_stage.sv */
module ex_stage #(
  parameter logic [31:0] MPU_BASE = 32'h0000_2000,
  parameter logic [31:0] MPU_SIZE = 32'h0000_1000
) (
  input  logic                      clk,
  input  logic                      reset_i,

  // Issuer side
  input  logic                      instr_valid_i,
  input  wb_pkg::op_e               instr_op_i,
  input  logic [wb_pkg::XLEN-1:0]   operand_a_i,
  input  logic [wb_pkg::XLEN-1:0]   operand_b_i,
  input  wb_pkg::rf_addr_t          instr_rd_i,
  output logic                      instr_ready_o,

  // Data bus request
  output logic                      data_req_o,
  output logic [wb_pkg::XLEN-1:0]   data_addr_o,

  // EX/WB pipeline
  input  logic                      wb_ready_i,
  output logic                      wb_instr_valid_o,
  output logic                      wb_op_load_o,
  output logic                      wb_rf_we_o,
  output wb_pkg::rf_addr_t          wb_rf_waddr_o,
  output logic [wb_pkg::XLEN-1:0]   wb_alu_result_o,
  output wb_pkg::mpu_status_e       wb_mpu_status_o
);

  import wb_pkg::*;

  // EX register
  logic              ex_valid;
  op_e               ex_op;
  logic [XLEN-1:0]   ex_a;
  logic [XLEN-1:0]   ex_b;
  rf_addr_t          ex_rd;

  // Request already issued for the load held in EX
  logic              req_sent;

  logic              instr_accept;
  logic              ex_is_load;
  logic [XLEN-1:0]   ex_addr;
  logic [XLEN-1:0]   ex_offset;
  logic              ex_in_region;
  logic [XLEN-1:0]   ex_result;
  mpu_status_e       ex_mpu_status;

  ////////////////////
  // EX register
  ////////////////////

  // EX is free when empty or when its content moves into WB
  assign instr_ready_o = !ex_valid || wb_ready_i;
  assign instr_accept  = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_valid <= 1'b0;
      req_sent <= 1'b0;
    end else begin
      if (instr_accept) begin
        ex_valid <= 1'b1;
        // New instruction has not requested yet
        req_sent <= 1'b0;
      end else begin
        if (wb_ready_i) begin
          ex_valid <= 1'b0;
        end
        // Remember the request while EX is stalled
        if (data_req_o) begin
          req_sent <= 1'b1;
        end
      end
    end
  end

  // Operands and destination, no reset needed
  always_ff @(posedge clk) begin
    if (instr_accept) begin
      ex_op <= instr_op_i;
      ex_a  <= operand_a_i;
      ex_b  <= operand_b_i;
      ex_rd <= instr_rd_i;
    end
  end

  ////////////////////
  // ALU and MPU
  ////////////////////

  assign ex_is_load = (ex_op == OP_LOAD);

  // Load address is operand a plus immediate
  assign ex_addr = ex_a + ex_b;

  always_comb begin
    case (ex_op)
      OP_ADD:  ex_result = ex_a + ex_b;
      OP_SUB:  ex_result = ex_a - ex_b;
      OP_AND:  ex_result = ex_a & ex_b;
      OP_OR:   ex_result = ex_a | ex_b;
      OP_XOR:  ex_result = ex_a ^ ex_b;
      OP_LOAD: ex_result = ex_addr;
      default: ex_result = '0;
    endcase
  end

  // Single region check, base inclusive and end exclusive
  assign ex_offset    = ex_addr - MPU_BASE;
  assign ex_in_region = (ex_addr >= MPU_BASE) && (ex_offset < MPU_SIZE);

  assign ex_mpu_status = (ex_is_load && !ex_in_region) ? MPU_FAULT : MPU_OK;

  // One request per load, only for a permitted address
  assign data_req_o  = ex_valid && ex_is_load && ex_in_region && !req_sent;
  assign data_addr_o = ex_addr;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_instr_valid_o <= 1'b0;
      wb_op_load_o     <= 1'b0;
      wb_rf_we_o       <= 1'b0;
    end else if (wb_ready_i) begin
      wb_instr_valid_o <= ex_valid;
      wb_op_load_o     <= ex_valid && ex_is_load;
      // x0 destination never writes
      wb_rf_we_o       <= ex_valid && (ex_rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      wb_rf_waddr_o   <= ex_rd;
      wb_alu_result_o <= ex_result;
      wb_mpu_status_o <= ex_mpu_status;
    end
  end

  // Bus never sees an address outside the permitted region
  a_req_in_region : assert property (@(posedge clk) disable iff (reset_i)
    data_req_o |-> (data_addr_o >= MPU_BASE) && ((data_addr_o - MPU_BASE) < MPU_SIZE));

  // A load held in EX does not request a second time
  a_req_once : assert property (@(posedge clk) disable iff (reset_i)
    data_req_o && !wb_ready_i |=> !data_req_o);

endmodule

/* verilog/lsu_resp_fifo.sv */
module lsu_resp_fifo #(
  parameter int RESP_DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      reset_i,

  // Write side from the data bus
  input  logic                      push_i,
  input  logic [wb_pkg::XLEN-1:0]   push_data_i,

  // Read side towards WB
  input  logic                      pop_i,
  output logic                      valid_o,
  output logic [wb_pkg::XLEN-1:0]   data_o
);

  import wb_pkg::*;

  localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESP_DEPTH + 1);

  // Response storage
  logic [XLEN-1:0]  mem [RESP_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(RESP_DEPTH));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // Simultaneous push and pop leave the count unchanged
      if (push_i && !pop_i) begin
        count <= count + CNT_W'(1);
      end else if (pop_i && !push_i) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Oldest response is visible the cycle after its push
  assign valid_o = !empty;
  assign data_o  = mem[rd_ptr];

  a_no_overflow : assert property (@(posedge clk) disable iff (reset_i)
    push_i && full |-> pop_i);

  a_no_underflow : assert property (@(posedge clk) disable iff (reset_i)
    pop_i |-> !empty);

endmodule

/* verilog/wb_stage.sv */
module wb_stage (
  // Clock and reset only feed the assertions
  input  logic                      clk,
  input  logic                      reset_i,

  // EX/WB pipeline
  input  logic                      instr_valid_i,
  input  logic                      op_load_i,
  input  logic                      rf_we_i,
  input  wb_pkg::rf_addr_t          rf_waddr_i,
  input  logic [wb_pkg::XLEN-1:0]   alu_result_i,
  input  wb_pkg::mpu_status_e       mpu_status_i,
  output logic                      wb_ready_o,

  // Load response FIFO
  input  logic                      resp_valid_i,
  input  logic [wb_pkg::XLEN-1:0]   resp_data_i,
  output logic                      resp_pop_o,

  // Pipeline control
  input  logic                      halt_wb_i,
  input  logic                      kill_wb_i,

  // Register file write port
  output logic                      rf_we_o,
  output wb_pkg::rf_addr_t          rf_waddr_o,
  output logic [wb_pkg::XLEN-1:0]   rf_wdata_o,

  // Status
  output logic                      wb_valid_o,
  output logic                      wb_exc_o,
  output logic                      data_stall_o
);

  import wb_pkg::*;

  logic instr_valid;
  logic lsu_exception;
  logic load_done;

  // Instruction is live unless halted or discarded
  assign instr_valid = instr_valid_i && !kill_wb_i && !halt_wb_i;

  // Only loads can fault, no request was sent for them
  assign lsu_exception = op_load_i && (mpu_status_i != MPU_OK);

  // Permitted load whose data sits at the FIFO head
  assign load_done = op_load_i && !lsu_exception && resp_valid_i && instr_valid;

  // Completion: ALU ops at once, loads with data, faulted loads at once
  assign wb_valid_o = ((!op_load_i) ||
                       (op_load_i && resp_valid_i && !lsu_exception) ||
                       lsu_exception) && instr_valid;

  assign wb_exc_o = wb_valid_o && lsu_exception;

  ////////////////////
  // Write back
  ////////////////////

  // Written once, on the completing cycle, never on a fault
  assign rf_we_o    = rf_we_i && !lsu_exception && wb_valid_o;
  assign rf_waddr_o = rf_waddr_i;
  assign rf_wdata_o = op_load_i ? resp_data_i : alu_result_i;

  assign resp_pop_o = load_done;

  // WB empties when it completes or is killed
  assign wb_ready_o = !instr_valid_i || kill_wb_i || wb_valid_o;

  // Waiting on load data
  assign data_stall_o = op_load_i && !lsu_exception && !resp_valid_i && instr_valid;

  // A load has its bus request outstanding and must not be dropped
  a_no_load_kill : assert property (@(posedge clk) disable iff (reset_i)
    instr_valid_i && op_load_i |-> !kill_wb_i);

  // FIFO is only popped by a completing load
  a_pop_with_data : assert property (@(posedge clk) disable iff (reset_i)
    resp_pop_o |-> resp_valid_i && wb_valid_o);

endmodule

/* verilog/reg_file.sv */
module reg_file (
  input  logic                      clk,
  input  logic                      reset_i,

  // Write port
  input  logic                      we_i,
  input  wb_pkg::rf_addr_t          waddr_i,
  input  logic [wb_pkg::XLEN-1:0]   wdata_i,

  // Read port, combinational
  input  wb_pkg::rf_addr_t          raddr_i,
  output logic [wb_pkg::XLEN-1:0]   rdata_o
);

  import wb_pkg::*;

  // x1 to x31, x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes to x0 are dropped
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

/* verilog/wb_subsys_top.sv */
module wb_subsys_top #(
  parameter logic [31:0] MPU_BASE   = 32'h0000_2000,
  parameter logic [31:0] MPU_SIZE   = 32'h0000_1000,
  parameter int          RESP_DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      reset_i,

  // Issuer
  input  logic                      instr_valid_i,
  input  wb_pkg::op_e               instr_op_i,
  input  logic [wb_pkg::XLEN-1:0]   operand_a_i,
  input  logic [wb_pkg::XLEN-1:0]   operand_b_i,
  input  wb_pkg::rf_addr_t          instr_rd_i,
  output logic                      instr_ready_o,

  // Data bus
  output logic                      data_req_o,
  output logic [wb_pkg::XLEN-1:0]   data_addr_o,
  input  logic                      data_rvalid_i,
  input  logic [wb_pkg::XLEN-1:0]   data_rdata_i,

  // Controller
  input  logic                      halt_wb_i,
  input  logic                      kill_wb_i,

  // Status
  output logic                      wb_valid_o,
  output logic                      wb_exc_o,
  output logic                      data_stall_o,

  // Register file read port
  input  wb_pkg::rf_addr_t          rf_raddr_i,
  output logic [wb_pkg::XLEN-1:0]   rf_rdata_o
);

  import wb_pkg::*;

  ////////////////////
  // Internal wiring
  ////////////////////

  // EX/WB pipeline
  logic            wb_ready;
  logic            wb_instr_valid;
  logic            wb_op_load;
  logic            wb_rf_we;
  rf_addr_t        wb_rf_waddr;
  logic [XLEN-1:0] wb_alu_result;
  mpu_status_e     wb_mpu_status;

  // Load responses
  logic            resp_pop;
  logic            resp_valid;
  logic [XLEN-1:0] resp_data;

  // Register file write
  logic            rf_we;
  rf_addr_t        rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  ex_stage #(
    .MPU_BASE (MPU_BASE),
    .MPU_SIZE (MPU_SIZE)
  ) ex_stage_i (
    .clk              (clk),
    .reset_i          (reset_i),
    .instr_valid_i    (instr_valid_i),
    .instr_op_i       (instr_op_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .instr_rd_i       (instr_rd_i),
    .instr_ready_o    (instr_ready_o),
    .data_req_o       (data_req_o),
    .data_addr_o      (data_addr_o),
    .wb_ready_i       (wb_ready),
    .wb_instr_valid_o (wb_instr_valid),
    .wb_op_load_o     (wb_op_load),
    .wb_rf_we_o       (wb_rf_we),
    .wb_rf_waddr_o    (wb_rf_waddr),
    .wb_alu_result_o  (wb_alu_result),
    .wb_mpu_status_o  (wb_mpu_status)
  );

  // Bus responses go straight into the FIFO
  lsu_resp_fifo #(
    .RESP_DEPTH (RESP_DEPTH)
  ) lsu_resp_fifo_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_i      (data_rvalid_i),
    .push_data_i (data_rdata_i),
    .pop_i       (resp_pop),
    .valid_o     (resp_valid),
    .data_o      (resp_data)
  );

  wb_stage wb_stage_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (wb_instr_valid),
    .op_load_i     (wb_op_load),
    .rf_we_i       (wb_rf_we),
    .rf_waddr_i    (wb_rf_waddr),
    .alu_result_i  (wb_alu_result),
    .mpu_status_i  (wb_mpu_status),
    .wb_ready_o    (wb_ready),
    .resp_valid_i  (resp_valid),
    .resp_data_i   (resp_data),
    .resp_pop_o    (resp_pop),
    .halt_wb_i     (halt_wb_i),
    .kill_wb_i     (kill_wb_i),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .wb_valid_o    (wb_valid_o),
    .wb_exc_o      (wb_exc_o),
    .data_stall_o  (data_stall_o)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .reset_i (reset_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

/* sim/tb_wb_subsys.sv */
module tb_wb_subsys;

  import wb_pkg::*;

  localparam logic [31:0] MPU_BASE   = 32'h0000_2000;
  localparam logic [31:0] MPU_SIZE   = 32'h0000_1000;
  localparam int          RESP_DEPTH = 2;
  localparam logic [31:0] LOAD_XOR   = 32'hA5A5_0000;
  localparam int          WAIT_LIMIT = 200;

  logic            clk;
  logic            reset_i;
  logic            instr_valid_i;
  op_e             instr_op_i;
  logic [XLEN-1:0] operand_a_i;
  logic [XLEN-1:0] operand_b_i;
  rf_addr_t        instr_rd_i;
  logic            instr_ready_o;
  logic            data_req_o;
  logic [XLEN-1:0] data_addr_o;
  logic            data_rvalid_i;
  logic [XLEN-1:0] data_rdata_i;
  logic            halt_wb_i;
  logic            kill_wb_i;
  logic            wb_valid_o;
  logic            wb_exc_o;
  logic            data_stall_o;
  rf_addr_t        rf_raddr_i;
  logic [XLEN-1:0] rf_rdata_o;

  // Reference model state
  op_e             q_op [$];
  logic [31:0]     q_a [$];
  logic [31:0]     q_b [$];
  rf_addr_t        q_rd [$];
  logic [31:0]     exp_rf [32];
  logic            ex_occ;
  logic            wb_occ;
  logic            h_load;
  logic            h_fault;
  int              resp_cnt;
  logic            chk_pend;
  rf_addr_t        chk_addr;
  logic [31:0]     chk_val;
  logic            exp_done;
  logic            exp_wb_rdy;
  logic            exp_ready;
  logic            exp_stall;

  int   err_cnt   = 0;
  int   err_base  = 0;
  int   n_done    = 0;
  int   done_base = 0;
  int   n_tests   = 0;
  logic timed_out = 1'b0;

  wb_subsys_top #(
    .MPU_BASE   (MPU_BASE),
    .MPU_SIZE   (MPU_SIZE),
    .RESP_DEPTH (RESP_DEPTH)
  ) dut0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .instr_rd_i    (instr_rd_i),
    .instr_ready_o (instr_ready_o),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .halt_wb_i     (halt_wb_i),
    .kill_wb_i     (kill_wb_i),
    .wb_valid_o    (wb_valid_o),
    .wb_exc_o      (wb_exc_o),
    .data_stall_o  (data_stall_o),
    .rf_raddr_i    (rf_raddr_i),
    .rf_rdata_o    (rf_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Reference rules
  ////////////////////

  function automatic logic in_region(input logic [31:0] addr);
    return (addr >= MPU_BASE) && (addr < MPU_BASE + MPU_SIZE);
  endfunction

  // A load writes back the memory pattern
  function automatic logic [31:0] ref_result(input op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_LOAD: return (a + b) ^ LOAD_XOR;
      default: return 32'h0;
    endcase
  endfunction

  // Expected WB behavior from the shadow pipeline
  assign exp_done   = wb_occ && !halt_wb_i && !kill_wb_i &&
                      (!h_load || h_fault || resp_cnt != 0);
  assign exp_wb_rdy = !wb_occ || kill_wb_i || exp_done;
  assign exp_ready  = !ex_occ || exp_wb_rdy;
  assign exp_stall  = wb_occ && h_load && !h_fault && resp_cnt == 0 && !halt_wb_i && !kill_wb_i;

  always @(posedge clk) begin : ref_model
    op_e         op;
    logic [31:0] a;
    logic [31:0] b;
    rf_addr_t    rd;
    if (reset_i) begin
      ex_occ   <= 1'b0;
      wb_occ   <= 1'b0;
      h_load   <= 1'b0;
      h_fault  <= 1'b0;
      resp_cnt <= 0;
      chk_pend <= 1'b0;
      chk_addr <= '0;
      chk_val  <= '0;
      for (int i = 0; i < 32; i++) begin
        exp_rf[i] = '0;
      end
    end else begin
      chk_pend <= 1'b0;
      // Completion or kill retires the oldest instruction
      if (exp_done || (wb_occ && kill_wb_i)) begin
        op = q_op.pop_front();
        a  = q_a.pop_front();
        b  = q_b.pop_front();
        rd = q_rd.pop_front();
        if (exp_done && !(op == OP_LOAD && !in_region(a + b)) && rd != '0) begin
          exp_rf[rd] = ref_result(op, a, b);
        end
        if (exp_done) begin
          n_done++;
        end
        // Read the destination back next cycle
        chk_pend <= 1'b1;
        chk_addr <= rd;
        chk_val  <= exp_rf[rd];
      end
      if (instr_valid_i && exp_ready) begin
        q_op.push_back(instr_op_i);
        q_a.push_back(operand_a_i);
        q_b.push_back(operand_b_i);
        q_rd.push_back(instr_rd_i);
      end
      if (exp_wb_rdy) begin
        wb_occ <= ex_occ;
      end
      if (instr_valid_i && exp_ready) begin
        ex_occ <= 1'b1;
      end else if (exp_wb_rdy) begin
        ex_occ <= 1'b0;
      end
      if (data_rvalid_i && !(exp_done && h_load && !h_fault)) begin
        resp_cnt <= resp_cnt + 1;
      end else if (!data_rvalid_i && exp_done && h_load && !h_fault) begin
        resp_cnt <= resp_cnt - 1;
      end
      // Oldest instruction is the one in WB
      if (q_op.size() > 0) begin
        h_load  <= (q_op[0] == OP_LOAD);
        h_fault <= (q_op[0] == OP_LOAD) && !in_region(q_a[0] + q_b[0]);
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  a_valid : assert property (@(posedge clk) disable iff (reset_i) wb_valid_o == exp_done)
    else begin
      err_cnt++;
      $display("** Error at %0t: wb_valid_o differs from expected completion", $time);
    end

  a_exc : assert property (@(posedge clk) disable iff (reset_i)
    wb_exc_o == (exp_done && h_load && h_fault))
    else begin
      err_cnt++;
      $display("** Error at %0t: wb_exc_o differs from expected fault", $time);
    end

  a_stall : assert property (@(posedge clk) disable iff (reset_i) data_stall_o == exp_stall)
    else begin
      err_cnt++;
      $display("** Error at %0t: data_stall_o differs from expected stall", $time);
    end

  a_ready : assert property (@(posedge clk) disable iff (reset_i) instr_ready_o == exp_ready)
    else begin
      err_cnt++;
      $display("** Error at %0t: instr_ready_o differs from expected", $time);
    end

  // Faulted loads never reach the bus
  a_req : assert property (@(posedge clk) disable iff (reset_i)
    data_req_o |-> in_region(data_addr_o))
    else begin
      err_cnt++;
      $display("** Error at %0t: bus request outside the MPU region", $time);
    end

  a_rd_value : assert property (@(posedge clk) disable iff (reset_i)
    chk_pend |-> rf_rdata_o == chk_val)
    else begin
      err_cnt++;
      $display("** Error at %0t: register x%0d holds a wrong value", $time, chk_addr);
    end

  a_x0 : assert property (@(posedge clk) disable iff (reset_i)
    rf_raddr_i == '0 |-> rf_rdata_o == '0)
    else begin
      err_cnt++;
      $display("** Error at %0t: x0 does not read as zero", $time);
    end

  ////////////////////
  // Memory and read port
  ////////////////////

  // Responses come in order 1 to 6 cycles after the head becomes oldest
  initial begin : mem_model
    logic [31:0] addr_q [$];
    int          lat_q [$];
    logic        fire;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever begin
      @(posedge clk);
      fire = 1'b0;
      if (!reset_i && data_req_o) begin
        addr_q.push_back(data_addr_o);
        lat_q.push_back($urandom_range(6, 1));
      end
      if (lat_q.size() > 0) begin
        lat_q[0] = lat_q[0] - 1;
        fire = (lat_q[0] <= 0);
      end
      #2;
      data_rvalid_i = fire;
      data_rdata_i  = '0;
      if (fire) begin
        data_rdata_i = addr_q.pop_front() ^ LOAD_XOR;
        void'(lat_q.pop_front());
      end
    end
  end

  initial begin : read_port
    rf_raddr_i = '0;
    forever begin
      @(posedge clk);
      #2;
      rf_raddr_i = chk_addr;
    end
  end

  initial begin : abort_on_timeout
    wait (timed_out);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Holds the instruction until EX takes it
  task automatic issue(input op_e op, input logic [31:0] a, input logic [31:0] b,
                       input rf_addr_t rd);
    logic accepted;
    int   n;
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    operand_a_i   = a;
    operand_b_i   = b;
    instr_rd_i    = rd;
    accepted      = 1'b0;
    n             = 0;
    while (!accepted && !timed_out) begin
      @(posedge clk);
      accepted = instr_ready_o;
      #2;
      n++;
      if (!accepted && n >= WAIT_LIMIT) begin
        $display("Timeout: instruction was not accepted within %0d cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic issue_alu();
    issue(op_e'($urandom_range(4, 0)), $urandom, $urandom, rf_addr_t'($urandom_range(31, 0)));
  endtask

  task automatic issue_load(input logic permitted);
    logic [31:0] a;
    logic [31:0] b;
    if (permitted) begin
      a = MPU_BASE + 4 * $urandom_range(511, 0);
      b = 4 * $urandom_range(511, 0);
    end else if ($urandom_range(1, 0) == 1) begin
      a = MPU_BASE + MPU_SIZE;
      b = 4 * $urandom_range(255, 0);
    end else begin
      a = MPU_BASE - 4 - 4 * $urandom_range(255, 0);
      b = '0;
    end
    issue(OP_LOAD, a, b, rf_addr_t'($urandom_range(31, 1)));
  endtask

  // Wait for the pipeline to empty
  task automatic drain();
    int n;
    n = 0;
    while ((q_op.size() != 0 || ex_occ || wb_occ) && !timed_out) begin
      @(posedge clk);
      #2;
      n++;
      if (n >= WAIT_LIMIT) begin
        $display("Timeout: pipeline did not drain within %0d cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic end_test(input string name);
    drain();
    n_tests++;
    $display("[%0t] %s finished, %0d completed, %0d errors", $time, name,
             n_done - done_base, err_cnt - err_base);
    done_base = n_done;
    err_base  = err_cnt;
  endtask

  initial begin : main
    int n;
    int r;
    void'($urandom(32'h53c6));
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_op_i    = OP_ADD;
    operand_a_i   = '0;
    operand_b_i   = '0;
    instr_rd_i    = '0;
    halt_wb_i     = 1'b0;
    kill_wb_i     = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // A write to x0 is dropped and x0 is read back
    issue(OP_OR, 32'hFFFF_FFFF, 32'h0000_0000, 5'd0);
    for (int i = 0; i < 24; i++) begin
      issue_alu();
    end
    end_test("alu_ops");

    for (int i = 0; i < 8; i++) begin
      issue_load(1'b1);
    end
    end_test("loads_in_region");

    for (int i = 0; i < 6; i++) begin
      issue_load(1'b0);
    end
    end_test("faulted_loads");

    // Load then ALU op pile up behind a halted WB
    halt_wb_i = 1'b1;
    issue_load(1'b1);
    issue_alu();
    n = 0;
    while (instr_ready_o && !timed_out) begin
      @(posedge clk);
      #2;
      n++;
      if (n >= WAIT_LIMIT) begin
        $display("Timeout: instr_ready_o did not fall while WB was halted");
        timed_out = 1'b1;
      end
    end
    repeat (8) @(posedge clk);
    #2;
    halt_wb_i = 1'b0;
    end_test("halt");

    // Victim reaches WB on the edge that accepts the follower
    issue(OP_ADD, 32'h1234_5678, 32'h0000_0001, 5'd7);
    issue(OP_XOR, $urandom, $urandom, 5'd9);
    kill_wb_i = 1'b1;
    @(posedge clk);
    #2;
    kill_wb_i = 1'b0;
    end_test("kill");

    for (int i = 0; i < 40; i++) begin
      r = $urandom_range(9, 0);
      if (r < 4) begin
        issue_load(1'b1);
      end else if (r == 4) begin
        issue_load(1'b0);
      end else begin
        issue_alu();
      end
    end
    end_test("mixed_loads");

    repeat (2) @(posedge clk);
    $display("Summary: %0d tests, %0d instructions completed, %0d errors",
             n_tests, n_done, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/wb_pkg.sv
verilog/ex_stage.sv
verilog/lsu_resp_fifo.sv
verilog/wb_stage.sv
verilog/reg_file.sv
verilog/wb_subsys_top.sv
sim/tb_wb_subsys.sv

/* Makefile */
TOP := tb_wb_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "Simulation ended early" && exit 1)

clean:
	rm -rf obj_dir sim.log
